// File: verification/tart_acquire_testdata.txt
# name op a b (hex). Q: queue sample a. S: spi_busy = a. W: write b to address a.
# R: read address a, expect b. C: expect cfg_o = a as {delay[2:0], debug, enabled}.
q_sample0 Q a1b2c3 0
q_sample1 Q 445566 0
q_sample2 Q 0789ab 0
rst_delay R 5 00
rst_debug R 6 00
rst_enable R 7 00
rst_cfg C 00 0
wr_delay W 5 0d
wr_delay_cfg C 14 0
wr_debug W 6 01
wr_enable W 7 ff
wr_all_cfg C 17 0
rd_delay R 5 05
rd_debug R 6 01
rd_enable R 7 01
wr_byte_hi W 1 ff
wr_byte_hi_cfg C 17 0
spi_on S 1 0
st0_hi R 0 a1
st0_mid R 0 b2
st0_lo R 0 c3
st1_hi R 0 44
st1_mid R 0 55
st1_lo R 0 66
st2_hi R 0 07
fix_hi R 1 07
fix_mid R 2 89
fix_lo R 3 ab
st2_mid R 0 89
spi_off S 0 0
spi_back S 1 0
st2_restart R 0 07
rd_unmapped R 4 00

// File: src.f
rtl/wb_pkg.sv
rtl/acq_pkg.sv
rtl/acq_bus_decode.sv
rtl/acq_ctrl_exec.sv
rtl/dram_prefetch.sv
rtl/acq_read_result.sv
rtl/tart_acquire_top.sv
verification/tb_tart_acquire.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_tart_acquire -f src.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vtb_tart_acquire > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Everything OK" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: verification/tb_tart_acquire.sv
`default_nettype none

module tb_tart_acquire;

   import wb_pkg::*;
   import acq_pkg::*;

   // Cycles allowed for any single wait.
   localparam int TIMEOUT = 50;

   logic        clk_i;
   logic        rst_i;
   // Host bus.
   logic        cyc;
   logic        stb;
   logic        we;
   wb_addr_t    adr;
   wb_data_t    wdat;
   logic        ack;
   wb_data_t    rdat;
   // Sample source and link.
   logic        data_ready;
   logic        data_request;
   sample_u     mem_data;
   logic        spi_busy;
   acq_cfg_t    cfg;

   // Memory model state.
   logic [23:0] mem_queue[$];
   int          gap;
   logic [31:0] rng_state;

   int          pass_count;
   int          fail_count;
   logic        timed_out;

   tart_acquire_top UUT (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cyc_i          (cyc),
      .stb_i          (stb),
      .we_i           (we),
      .adr_i          (adr),
      .dat_i          (wdat),
      .ack_o          (ack),
      .dat_o          (rdat),
      .data_ready_i   (data_ready),
      .data_request_o (data_request),
      .data_i         (mem_data),
      .spi_busy_i     (spi_busy),
      .cfg_o          (cfg)
   );

   // Period of 4.
   always #2 clk_i = ~clk_i;

   // ----------------------------------------------------------------------
   // Memory model.
   // ----------------------------------------------------------------------

   // 32-bit xorshift step.
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Answers an open request after 1 to 4 idle cycles.
   // Ready lasts one cycle.
   // The request drops after it.
   always @(negedge clk_i) begin
      if (data_ready) begin
         data_ready = 1'b0;
         // Word was taken on the last rising edge.
         compare_request("request_drop", 1'b0, data_request);
      end else if (rst_i || !data_request || mem_queue.size() == 0) begin
         data_ready = 1'b0;
      end else if (gap > 0) begin
         gap = gap - 1;
      end else begin
         mem_data.word = mem_queue.pop_front();
         data_ready    = 1'b1;
         rng_state     = xorshift32(rng_state);
         gap           = int'(rng_state % 4) + 1;
      end
   end

   // ----------------------------------------------------------------------
   // Compare tasks.
   // ----------------------------------------------------------------------

   task automatic check_byte(input string name, input wb_data_t exp, input wb_data_t act);
      if (act === exp) begin
         pass_count++;
         $display("ok   %s read %h", name, act);
      end else begin
         fail_count++;
         $display("Fail %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_cfg(input string name, input acq_cfg_t exp, input acq_cfg_t act);
      if (act === exp) begin
         pass_count++;
         $display("ok   %s settings %h", name, act);
      end else begin
         fail_count++;
         $display("Fail %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic compare_request(input string name, input logic exp, input logic act);
      if (act === exp) begin
         pass_count++;
         $display("ok   %s request %b", name, act);
      end else begin
         fail_count++;
         $display("Fail %s expected %b actual %b", name, exp, act);
      end
   endtask

   // ----------------------------------------------------------------------
   // Bus driver.
   // ----------------------------------------------------------------------

   // Called on a falling edge.
   // Holds stb up until ack arrives.
   // Stream reads stall here on back-pressure.
   task automatic bus_transfer(input string name, input logic write, input wb_addr_t a,
                               input wb_data_t d, output wb_data_t q);
      int    n;
      string kind;
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = write;
      adr  = a;
      wdat = d;
      n    = 0;
      do begin
         @(negedge clk_i);
         n++;
      end while (!ack && n < TIMEOUT);
      q   = rdat;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      if (!ack) begin
         if (write) begin
            kind = "write";
         end else begin
            kind = "read";
         end
         timed_out = 1'b1;
         fail_count++;
         $display("%s: no acknowledge for %s at address %0d", name, kind, a);
      end
   endtask

   // ----------------------------------------------------------------------
   // Test sequence from the data file.
   // ----------------------------------------------------------------------

   initial begin
      string       line;
      string       name;
      string       op;
      logic [31:0] a;
      logic [31:0] b;
      wb_data_t    q;
      int          fd;
      clk_i      = 1'b0;
      rst_i      = 1'b1;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      wdat       = '0;
      data_ready = 1'b0;
      mem_data   = '0;
      spi_busy   = 1'b0;
      rng_state  = 32'd42;
      gap        = 1;
      pass_count = 0;
      fail_count = 0;
      timed_out  = 1'b0;
      repeat (4) @(negedge clk_i);
      rst_i = 1'b0;
      // Empty holder asks for a word right after reset.
      compare_request("rst_request", 1'b1, data_request);
      fd = $fopen("verification/tart_acquire_testdata.txt", "r");
      if (fd == 0) begin
         fail_count++;
         $display("could not open the test data file");
      end else begin
         while (!timed_out && $fgets(line, fd) > 0) begin
            // Blank lines and # lines carry no test.
            if (line.len() > 1 && line.getc(0) != "#") begin
               void'($sscanf(line, "%s %s %h %h", name, op, a, b));
               case (op.getc(0))
                  "Q": mem_queue.push_back(a[23:0]);
                  "S": begin
                     spi_busy = a[0];
                     @(negedge clk_i);
                  end
                  "W": begin
                     bus_transfer(name, 1'b1, a[2:0], b[7:0], q);
                     if (!timed_out) begin
                        pass_count++;
                        $display("ok   %s write acknowledged", name);
                     end
                  end
                  "R": begin
                     bus_transfer(name, 1'b0, a[2:0], 8'h00, q);
                     if (!timed_out) begin
                        check_byte(name, b[7:0], q);
                     end
                  end
                  "C": check_cfg(name, acq_cfg_t'(a[4:0]), cfg);
                  default: begin
                     fail_count++;
                     $display("%s: unknown operation in the test data file", name);
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/tart_acquire_top.sv
`default_nettype none

module tart_acquire_top (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   // Host bus.
   input  wire logic              cyc_i,
   input  wire logic              stb_i,
   input  wire logic              we_i,
   input  wire wb_pkg::wb_addr_t  adr_i,
   input  wire wb_pkg::wb_data_t  dat_i,
   output      logic              ack_o,
   output      wb_pkg::wb_data_t  dat_o,
   // Sample source.
   input  wire logic              data_ready_i,
   output      logic              data_request_o,
   input  wire acq_pkg::sample_u  data_i,
   // Link and capture side.
   input  wire logic              spi_busy_i,
   output      acq_pkg::acq_cfg_t cfg_o
);

   import wb_pkg::*;
   import acq_pkg::*;

   // ----------------------------------------------------------------------
   // Internal wiring.
   // ----------------------------------------------------------------------

   wb_req_t    bus_req;
   acq_cmd_t   cmd;
   acq_cfg_t   cfg;
   sample_u    sample;
   logic       sample_valid;
   logic       sample_sent;
   logic [1:0] stream_index;

   // Bus pins bundled for the decoder.
   assign bus_req = '{cyc: cyc_i, stb: stb_i, we: we_i, adr: adr_i, dat: dat_i};

   // ----------------------------------------------------------------------
   // Blocks.
   // ----------------------------------------------------------------------

   // Bus cycles to commands.
   acq_bus_decode u_decode (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .req_i          (bus_req),
      .sample_valid_i (sample_valid),
      .cmd_o          (cmd),
      .ack_o          (ack_o)
   );

   // Settings and stream position.
   acq_ctrl_exec u_exec (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .spi_busy_i     (spi_busy_i),
      .cmd_i          (cmd),
      .cfg_o          (cfg),
      .stream_index_o (stream_index),
      .sample_sent_o  (sample_sent)
   );

   // Sample holder toward memory.
   dram_prefetch u_prefetch (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .data_ready_i   (data_ready_i),
      .data_request_o (data_request_o),
      .data_i         (data_i),
      .sample_sent_i  (sample_sent),
      .sample_o       (sample),
      .sample_valid_o (sample_valid)
   );

   // Read data back to the host.
   acq_read_result u_result (
      .clk_i          (clk_i),
      .cmd_i          (cmd),
      .sample_i       (sample),
      .stream_index_i (stream_index),
      .cfg_i          (cfg),
      .dat_o          (dat_o)
   );

   assign cfg_o = cfg;

endmodule

`default_nettype wire

// File: rtl/acq_read_result.sv
`default_nettype none

module acq_read_result (
   input  wire logic              clk_i,
   input  wire acq_pkg::acq_cmd_t cmd_i,
   input  wire acq_pkg::sample_u  sample_i,
   input  wire logic [1:0]        stream_index_i,
   input  wire acq_pkg::acq_cfg_t cfg_i,
   output      wb_pkg::wb_data_t  dat_o
);

   import wb_pkg::*;
   import acq_pkg::*;

   // Read of any kind this cycle.
   logic       rd;
   // Byte slot picked by the stream index.
   logic [1:0] byte_sel;
   // Selected read value.
   wb_data_t   rd_data;
   // Read data register.
   wb_data_t   dat_q;

   // ----------------------------------------------------------------------
   // Read mux.
   // ----------------------------------------------------------------------

   always_comb begin
      rd       = (cmd_i.op == OP_READ) || (cmd_i.op == OP_STREAM);
      // Index 0 is the high byte.
      byte_sel = 2'(SAMPLE_BYTES - 1) - stream_index_i;
      if (cmd_i.op == OP_STREAM) begin
         rd_data = sample_i.bytes[byte_sel];
      end else begin
         case (cmd_i.adr)
            ADR_BYTE_HI:  rd_data = sample_i.bytes[2];
            ADR_BYTE_MID: rd_data = sample_i.bytes[1];
            ADR_BYTE_LO:  rd_data = sample_i.bytes[0];
            // Settings, zero-extended.
            ADR_DELAY:    rd_data = wb_data_t'(cfg_i.sample_delay);
            ADR_DEBUG:    rd_data = wb_data_t'(cfg_i.debug_mode);
            ADR_STATUS:   rd_data = wb_data_t'(cfg_i.enabled);
            // Unmapped slot.
            default:      rd_data = '0;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Read data register.
   // ----------------------------------------------------------------------

   // Loaded on the ack edge, held otherwise.
   always_ff @(posedge clk_i) begin
      if (rd) begin
         dat_q <= rd_data;
      end
   end

   assign dat_o = dat_q;

endmodule

`default_nettype wire

// File: rtl/dram_prefetch.sv
`default_nettype none

module dram_prefetch (
   input  wire logic             clk_i,
   input  wire logic             rst_i,
   input  wire logic             data_ready_i,
   output      logic             data_request_o,
   input  wire acq_pkg::sample_u data_i,
   input  wire logic             sample_sent_i,
   output      acq_pkg::sample_u sample_o,
   output      logic             sample_valid_o
);

   import acq_pkg::*;

   // ----------------------------------------------------------------------
   // One-entry holder.
   // ----------------------------------------------------------------------

   // Held antenna sample.
   sample_u sample_q;
   // Holder is full.
   logic    valid_q;
   // Word arrives while empty.
   logic    capture;

   // The source only answers an open request.
   assign capture = !valid_q && data_ready_i;

   // ----------------------------------------------------------------------
   // Valid flag.
   // ----------------------------------------------------------------------

   // Empty after reset, so a fetch starts at once.
   // Consumption wins, a full holder ignores ready.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else if (sample_sent_i) begin
         valid_q <= 1'b0;
      end else if (capture) begin
         valid_q <= 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Sample payload.
   // ----------------------------------------------------------------------

   // Word taken in the ready cycle.
   // Kept until the next capture.
   always_ff @(posedge clk_i) begin
      if (capture) begin
         sample_q <= data_i;
      end
   end

   // ----------------------------------------------------------------------
   // Memory request.
   // ----------------------------------------------------------------------

   // High while empty.
   // Drops the cycle after capture.
   assign data_request_o = !valid_q;

   assign sample_o       = sample_q;
   assign sample_valid_o = valid_q;

endmodule

`default_nettype wire

// File: rtl/acq_ctrl_exec.sv
`default_nettype none

module acq_ctrl_exec (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire logic              spi_busy_i,
   input  wire acq_pkg::acq_cmd_t cmd_i,
   output      acq_pkg::acq_cfg_t cfg_o,
   output      logic [1:0]        stream_index_o,
   output      logic              sample_sent_o
);

   import wb_pkg::*;
   import acq_pkg::*;

   // Index of the low byte, last in the stream.
   localparam logic [1:0] LAST_INDEX = 2'(SAMPLE_BYTES - 1);

   // ----------------------------------------------------------------------
   // Decoded strobes.
   // ----------------------------------------------------------------------

   // Register write this cycle.
   logic       wr;
   // Stream byte read this cycle.
   logic       stream;
   // Stream index is on the last byte.
   logic       at_last;
   // Index after this stream byte.
   logic [1:0] index_next;

   // Settings register.
   acq_cfg_t   cfg_q;
   // Stream byte index.
   logic [1:0] index_q;
   // Sample consumed pulse.
   logic       sent_q;

   always_comb begin
      wr         = (cmd_i.op == OP_WRITE);
      stream     = (cmd_i.op == OP_STREAM);
      at_last    = (index_q == LAST_INDEX);
      // Wraps back to the high byte.
      index_next = at_last ? 2'd0 : index_q + 2'd1;
   end

   // ----------------------------------------------------------------------
   // Settings registers.
   // ----------------------------------------------------------------------

   // Written on the ack edge, visible with ack.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cfg_q <= '0;
      end else if (wr) begin
         case (cmd_i.adr)
            ADR_DELAY:  cfg_q.sample_delay <= cmd_i.dat[2:0];
            ADR_DEBUG:  cfg_q.debug_mode   <= cmd_i.dat[0];
            ADR_STATUS: cfg_q.enabled      <= cmd_i.dat[0];
            // Read-only and unmapped slots.
            default:    cfg_q              <= cfg_q;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Stream index and sample consumption.
   // ----------------------------------------------------------------------

   // Idle link restarts the stream at the high byte.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         index_q <= 2'd0;
      end else if (!spi_busy_i) begin
         index_q <= 2'd0;
      end else if (stream) begin
         index_q <= index_next;
      end
   end

   // Pulse after the low byte leaves.
   // Tells the prefetcher to drop its sample
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sent_q <= 1'b0;
      end else begin
         sent_q <= stream && at_last;
      end
   end

   assign cfg_o          = cfg_q;
   assign stream_index_o = index_q;
   assign sample_sent_o  = sent_q;

endmodule

`default_nettype wire

// File: rtl/acq_bus_decode.sv
`default_nettype none

module acq_bus_decode (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire wb_pkg::wb_req_t   req_i,
   input  wire logic              sample_valid_i,
   output      acq_pkg::acq_cmd_t cmd_o,
   output      logic              ack_o
);

   import wb_pkg::*;
   import acq_pkg::*;

   // ----------------------------------------------------------------------
   // Transfer acceptance.
   // ----------------------------------------------------------------------

   // Read at the stream slot.
   logic    is_stream;
   // Transfer taken on the coming edge.
   logic    accept;
   // Kind of the accepted transfer.
   acq_op_e op;
   // Acknowledge register.
   logic    ack_q;

   always_comb begin
      is_stream = !req_i.we && (req_i.adr == ADR_STREAM);
      // Live request, not the cycle being acknowledged.
      accept    = req_i.cyc && req_i.stb && !ack_q;
      // Stream reads wait for a held sample.
      // The master keeps stb up meanwhile.
      if (is_stream && !sample_valid_i) begin
         accept = 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // Classification.
   // ----------------------------------------------------------------------

   always_comb begin
      if (!accept) begin
         op = OP_NONE;
      end else if (req_i.we) begin
         op = OP_WRITE;
      end else if (is_stream) begin
         op = OP_STREAM;
      end else begin
         op = OP_READ;
      end
   end

   // Command is live in the sampling cycle only.
   // Downstream registers take it on the ack edge.
   always_comb begin
      cmd_o.op  = op;
      cmd_o.adr = req_i.adr;
      cmd_o.dat = req_i.dat;
   end

   // ----------------------------------------------------------------------
   // Acknowledge.
   // ----------------------------------------------------------------------

   // One cycle high per accepted transfer.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;
      end
   end

   assign ack_o = ack_q;

endmodule

`default_nettype wire

// File: rtl/acq_pkg.sv
`default_nettype none

package acq_pkg;

   // ----------------------------------------------------------------------
   // Antenna sample.
   // ----------------------------------------------------------------------

   // Bytes per antenna sample.
   localparam int SAMPLE_BYTES = 3;

   // One word, two readings of it.
   // Flat view for the memory side.
   // Byte view for the register side, index 2 is the high byte.
   typedef union packed {
      logic [SAMPLE_BYTES*8-1:0]               word;
      wb_pkg::wb_data_t [SAMPLE_BYTES-1:0]     bytes;
   } sample_u;

   // ----------------------------------------------------------------------
   // Acquisition settings.
   // ----------------------------------------------------------------------

   // Driven out to the capture logic.
   typedef struct packed {
      logic [2:0] sample_delay;
      logic       debug_mode;
      logic       enabled;
   } acq_cfg_t;

   // ----------------------------------------------------------------------
   // Decoded bus transfer.
   // ----------------------------------------------------------------------

   // Kind of transfer accepted this cycle.
   typedef enum logic [1:0] {
      OP_NONE,
      OP_READ,
      OP_WRITE,
      OP_STREAM
   } acq_op_e;

   // One transfer, live for a single cycle.
   typedef struct packed {
      acq_op_e          op;
      wb_pkg::wb_addr_t adr;
      wb_pkg::wb_data_t dat;
   } acq_cmd_t;

endpackage

`default_nettype wire

// File: rtl/wb_pkg.sv
`default_nettype none

package wb_pkg;

   // ----------------------------------------------------------------------
   // Bus word types.
   // ----------------------------------------------------------------------

   // One byte on the host bus.
   typedef logic [7:0] wb_data_t;

   // Eight register slots.
   typedef logic [2:0] wb_addr_t;

   // Request as seen by the slave, one bundle per cycle.
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   // ----------------------------------------------------------------------
   // Register map.
   // ----------------------------------------------------------------------

   // Antenna byte stream, high byte first.
   localparam wb_addr_t ADR_STREAM   = 3'd0;
   // Fixed views of the held sample.
   localparam wb_addr_t ADR_BYTE_HI  = 3'd1;
   localparam wb_addr_t ADR_BYTE_MID = 3'd2;
   localparam wb_addr_t ADR_BYTE_LO  = 3'd3;
   // Slot 4 is left unmapped, reads as zero.
   // Acquisition settings.
   localparam wb_addr_t ADR_DELAY    = 3'd5;
   localparam wb_addr_t ADR_DEBUG    = 3'd6;
   localparam wb_addr_t ADR_STATUS   = 3'd7;

endpackage

`default_nettype wire
